/* verilog/pipePkg.sv */
package pipePkg;

	localparam int DataWidth = 32;

	// cause codes as they appear in the cause register.
	typedef enum logic [4:0] {
		AdEL = 5'd4,
		AdES = 5'd5,
		Ov = 5'd12,
		None = 5'd15
	} excCode;

	// data memory access sizes where loads have the top bit set.
	typedef enum logic [2:0] {
		noAccess = 3'd0,
		storeHalf = 3'd1,
		storeWord = 3'd2,
		loadHalfSigned = 3'd5,
		loadHalfUnsigned = 3'd6,
		loadWord = 3'd7
	} accessSize;

	localparam logic [DataWidth-1:0] resetVectorDefault = 32'hbfc0_0000;
	localparam logic [DataWidth-1:0] excVectorDefault = 32'hbfc0_0380; // general exception entry.
	localparam int flushCyclesDefault = 3;

endpackage

/* verilog/excBus.sv */
interface excBus;

	logic valid;
	pipePkg::excCode code;
	logic [pipePkg::DataWidth-1:0] pc;
	logic [pipePkg::DataWidth-1:0] badVAddr;
	logic inDelaySlot;

	modport source(
		output valid, code, pc, badVAddr, inDelaySlot
	);

	modport sink(
		input valid, code, pc, badVAddr, inDelaySlot
	);

endinterface

/* verilog/fetchStage.sv */
module fetchStage #(
	parameter logic [pipePkg::DataWidth-1:0] ResetVector = pipePkg::resetVectorDefault,
	parameter logic [pipePkg::DataWidth-1:0] ExcVector = pipePkg::excVectorDefault
) (
	input logic clk,
	input logic rst,
	input logic pcWr,
	input logic ifIdWr,
	input logic flush,
	input logic redirect,
	input logic [pipePkg::DataWidth-1:0] npc,
	input logic [pipePkg::DataWidth-1:0] instrData,
	output logic [pipePkg::DataWidth-1:0] pc,
	output logic [pipePkg::DataWidth-1:0] idPc,
	output logic [pipePkg::DataWidth-1:0] idInstr,
	output logic idAdEL
);

	logic [pipePkg::DataWidth-1:0] prePc;
	logic prePcAdEL;
	logic pcAdEL;

	// the fetch address is checked when it enters prePc and the flag follows it down.
	always_ff @(posedge clk) begin
		if (!rst) begin
			prePc <= ResetVector;
			prePcAdEL <= 1'b0;
			pc <= '0;
			pcAdEL <= 1'b0;
		end else if (redirect) begin
			prePc <= ExcVector;
			prePcAdEL <= 1'b0;
			pc <= ExcVector;
			pcAdEL <= 1'b0;
		end else if (pcWr) begin
			prePc <= npc;
			prePcAdEL <= (npc[1:0] != 2'b00);
			pc <= prePc;
			pcAdEL <= prePcAdEL;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst || flush) begin // a flushed slot reads as a nop.
			idPc <= '0;
			idInstr <= '0;
			idAdEL <= 1'b0;
		end else if (ifIdWr) begin
			idPc <= pc;
			idInstr <= instrData;
			idAdEL <= pcAdEL;
		end
	end

endmodule

/* verilog/memCheck.sv */
module memCheck (
	input logic clk,
	input logic rst,
	input logic flush,
	input logic dmWr,
	input logic dmRd,
	input logic overflow,
	input logic pendingExc,
	input logic isBd,
	input pipePkg::excCode pendingCode,
	input pipePkg::accessSize size,
	input logic [pipePkg::DataWidth-1:0] addr,
	input logic [pipePkg::DataWidth-1:0] exPc,
	excBus.source report
);

	logic wordMisaligned;
	logic halfMisaligned;
	logic storeBad;
	logic loadBad;
	logic nextValid;
	pipePkg::excCode nextCode;
	logic [pipePkg::DataWidth-1:0] nextBadVAddr;

	assign wordMisaligned = (addr[1:0] != 2'b00);
	assign halfMisaligned = addr[0];

	assign storeBad = dmWr && ((size == pipePkg::storeWord && wordMisaligned) ||
		(size == pipePkg::storeHalf && halfMisaligned));

	assign loadBad = dmRd && ((size == pipePkg::loadWord && wordMisaligned) ||
		((size == pipePkg::loadHalfSigned || size == pipePkg::loadHalfUnsigned) &&
		halfMisaligned));

	// an exception raised earlier in the pipe always wins because it belongs to an older stage.
	always_comb begin
		nextValid = 1'b1;
		nextCode = pipePkg::None;
		nextBadVAddr = exPc;
		if (pendingExc) begin
			nextCode = pendingCode;
		end else if (overflow) begin
			nextCode = pipePkg::Ov;
		end else if (storeBad) begin
			nextCode = pipePkg::AdES;
			nextBadVAddr = addr;
		end else if (loadBad) begin
			nextCode = pipePkg::AdEL;
			nextBadVAddr = addr;
		end else begin
			nextValid = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst || flush) begin
			report.valid <= 1'b0;
			report.code <= pipePkg::None;
			report.pc <= '0;
			report.badVAddr <= '0;
			report.inDelaySlot <= 1'b0;
		end else begin
			report.valid <= nextValid;
			report.code <= nextCode;
			report.pc <= exPc;
			report.badVAddr <= nextBadVAddr;
			report.inDelaySlot <= isBd;
		end
	end

endmodule

/* verilog/excControl.sv */
module excControl (
	input logic clk,
	input logic rst,
	input logic timerDone,
	excBus.sink report,
	output logic take,
	output logic startTimer,
	output logic flush,
	output logic redirect,
	output logic excTaken
);

	typedef enum logic [1:0] {
		stateRun,
		stateFlush,
		stateRedirect
	} ctrlState;

	ctrlState state;
	ctrlState nextState;

	always_comb begin
		nextState = state;
		case (state)
			stateRun: begin
				if (report.valid) nextState = stateFlush;
			end
			stateFlush: begin
				if (timerDone) nextState = stateRedirect;
			end
			stateRedirect: begin
				nextState = stateRun; // fetch restarts at the vector.
			end
			default: begin
				nextState = stateRun;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= stateRun;
		end else begin
			state <= nextState;
		end
	end

	// reports seen while flushing or redirecting belong to squashed instructions.
	assign take = (state == stateRun) && report.valid;
	assign startTimer = take;
	assign excTaken = take;
	assign flush = (state == stateFlush);
	assign redirect = (state == stateRedirect);

endmodule

/* verilog/flushTimer.sv */
module flushTimer #(
	parameter int FlushCycles = pipePkg::flushCyclesDefault
) (
	input logic clk,
	input logic rst,
	input logic start,
	output logic done
);

	localparam int CountWidth = $clog2(FlushCycles + 1);

	logic [CountWidth-1:0] count;
	logic running;

	always_ff @(posedge clk) begin
		if (!rst) begin
			count <= '0;
			running <= 1'b0;
		end else if (start) begin
			count <= CountWidth'(FlushCycles - 1); // the first counted cycle follows start.
			running <= 1'b1;
		end else if (running) begin
			if (count == '0) running <= 1'b0;
			else count <= count - 1'b1;
		end
	end

	assign done = running && (count == '0);

endmodule

/* verilog/excRecord.sv */
module excRecord (
	input logic clk,
	input logic rst,
	input logic take,
	excBus.sink report,
	output logic [pipePkg::DataWidth-1:0] epc,
	output logic [pipePkg::DataWidth-1:0] badVAddr,
	output pipePkg::excCode code,
	output logic branchDelay
);

	logic [pipePkg::DataWidth-1:0] restartPc;

	// a faulting delay slot restarts at its branch.
	assign restartPc = report.inDelaySlot ? report.pc - 32'd4 : report.pc;

	always_ff @(posedge clk) begin
		if (!rst) begin
			epc <= '0;
			badVAddr <= '0;
			code <= pipePkg::None;
			branchDelay <= 1'b0;
		end else if (take) begin
			epc <= restartPc;
			badVAddr <= report.badVAddr;
			code <= report.code;
			branchDelay <= report.inDelaySlot;
		end
	end

endmodule

/* verilog/exceptionPipe.sv */
module exceptionPipe #(
	parameter logic [pipePkg::DataWidth-1:0] ResetVector = pipePkg::resetVectorDefault,
	parameter logic [pipePkg::DataWidth-1:0] ExcVector = pipePkg::excVectorDefault,
	parameter int FlushCycles = pipePkg::flushCyclesDefault
) (
	input logic clk,
	input logic rst,
	input logic [pipePkg::DataWidth-1:0] npc,
	input logic pcWr,
	input logic [pipePkg::DataWidth-1:0] instrData,
	input logic ifIdWr,
	input logic dmWr,
	input logic dmRd,
	input pipePkg::accessSize size,
	input logic [pipePkg::DataWidth-1:0] addr,
	input logic [pipePkg::DataWidth-1:0] exPc,
	input logic overflow,
	input logic pendingExc,
	input pipePkg::excCode pendingCode,
	input logic isBd,
	output logic [pipePkg::DataWidth-1:0] pc,
	output logic [pipePkg::DataWidth-1:0] idPc,
	output logic [pipePkg::DataWidth-1:0] idInstr,
	output logic idAdEL,
	output logic excTaken,
	output logic flushing,
	output logic [pipePkg::DataWidth-1:0] epc,
	output pipePkg::excCode excCode,
	output logic [pipePkg::DataWidth-1:0] badVAddr,
	output logic branchDelay
);

	logic take;
	logic startTimer;
	logic timerDone;
	logic flush;
	logic redirect;

	excBus report ();

	fetchStage #(
		.ResetVector(ResetVector),
		.ExcVector(ExcVector)
	) fetch (
		.clk(clk),
		.rst(rst),
		.pcWr(pcWr),
		.ifIdWr(ifIdWr),
		.flush(flush),
		.redirect(redirect),
		.npc(npc),
		.instrData(instrData),
		.pc(pc),
		.idPc(idPc),
		.idInstr(idInstr),
		.idAdEL(idAdEL)
	);

	memCheck check (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.dmWr(dmWr),
		.dmRd(dmRd),
		.overflow(overflow),
		.pendingExc(pendingExc),
		.isBd(isBd),
		.pendingCode(pendingCode),
		.size(size),
		.addr(addr),
		.exPc(exPc),
		.report(report.source)
	);

	excControl control (
		.clk(clk),
		.rst(rst),
		.timerDone(timerDone),
		.report(report.sink),
		.take(take),
		.startTimer(startTimer),
		.flush(flush),
		.redirect(redirect),
		.excTaken(excTaken)
	);

	flushTimer #(
		.FlushCycles(FlushCycles)
	) timer (
		.clk(clk),
		.rst(rst),
		.start(startTimer),
		.done(timerDone)
	);

	excRecord record (
		.clk(clk),
		.rst(rst),
		.take(take),
		.report(report.sink),
		.epc(epc),
		.badVAddr(badVAddr),
		.code(excCode),
		.branchDelay(branchDelay)
	);

	assign flushing = flush;

endmodule

/* testbench/exceptionPipeTb.sv */
module exceptionPipeTb;

	localparam logic [31:0] ResetVector = pipePkg::resetVectorDefault;
	localparam logic [31:0] ExcVector = pipePkg::excVectorDefault;
	localparam int FlushCycles = pipePkg::flushCyclesDefault;
	localparam int WaitLimit = 6; // cycles a row may take to show up on excTaken.
	localparam int FlushLimit = FlushCycles + 8;

	typedef struct packed {
		pipePkg::accessSize size;
		logic [1:0] addrLow;
		logic [4:0] flags; // overflow, pendingExc, isBd, addr is bad, squash during flush.
		pipePkg::excCode pendingCode;
		pipePkg::excCode expCode;
	} rowEntry;

	logic clk;
	logic rst;
	logic [31:0] npc;
	logic pcWr;
	logic [31:0] instrData;
	logic ifIdWr;
	logic dmWr;
	logic dmRd;
	pipePkg::accessSize size;
	logic [31:0] addr;
	logic [31:0] exPc;
	logic overflow;
	logic pendingExc;
	pipePkg::excCode pendingCode;
	logic isBd;
	logic [31:0] pc;
	logic [31:0] idPc;
	logic [31:0] idInstr;
	logic idAdEL;
	logic excTaken;
	logic flushing;
	logic [31:0] epc;
	pipePkg::excCode excCode;
	logic [31:0] badVAddr;
	logic branchDelay;

	rowEntry rows[$];
	int checkCount;
	int errorCount;
	int testCount;
	int testErrors;
	logic [31:0] modelPrePc;
	logic [31:0] modelPc;
	logic [31:0] modelIdPc;
	logic [31:0] modelIdInstr;
	logic modelPreAdEL;
	logic modelPcAdEL;
	logic modelIdAdEL;

	exceptionPipe uut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic nextCycle();
		@(posedge clk);
		#1;
	endtask

	function automatic logic [31:0] randWord();
		return $urandom;
	endfunction

	task automatic expectEq(input string name, input logic [31:0] got, input logic [31:0] want);
		checkCount++;
		assert (got === want) else begin
			errorCount++;
			$display("** Error @ %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("** Failure @ %0t: %s", $time, what);
	endtask

	task automatic beginTest();
		testErrors = errorCount;
	endtask

	task automatic endTest(input string name);
		testCount++;
		if (errorCount == testErrors) $display("test %0d %s: ok", testCount, name);
		else $display("test %0d %s: %0d errors", testCount, name, errorCount - testErrors);
	endtask

	task automatic driveIdle();
		dmWr = 1'b0;
		dmRd = 1'b0;
		size = pipePkg::noAccess;
		addr = '0;
		exPc = '0;
		overflow = 1'b0;
		pendingExc = 1'b0;
		pendingCode = pipePkg::None;
		isBd = 1'b0;
	endtask

	// IF/ID sees the pc stage as it was before the edge, so it is updated first.
	task automatic stepFetchModel();
		if (ifIdWr) begin
			modelIdPc = modelPc;
			modelIdInstr = instrData;
			modelIdAdEL = modelPcAdEL;
		end
		if (pcWr) begin
			modelPc = modelPrePc;
			modelPcAdEL = modelPreAdEL;
			modelPrePc = npc;
			modelPreAdEL = (npc[1:0] != 2'b00);
		end
	endtask

	task automatic addRow(input pipePkg::accessSize rowSize, input logic [1:0] rowLow,
		input logic [4:0] rowFlags, input pipePkg::excCode rowPending,
		input pipePkg::excCode rowExpect);
		rowEntry r;
		r.size = rowSize;
		r.addrLow = rowLow;
		r.flags = rowFlags;
		r.pendingCode = rowPending;
		r.expCode = rowExpect;
		rows.push_back(r);
	endtask

	task automatic buildTable();
		addRow(pipePkg::storeWord, 2'd0, 5'b00000, pipePkg::None, pipePkg::None);
		addRow(pipePkg::storeWord, 2'd2, 5'b00010, pipePkg::None, pipePkg::AdES);
		addRow(pipePkg::storeWord, 2'd1, 5'b00110, pipePkg::None, pipePkg::AdES);
		addRow(pipePkg::storeHalf, 2'd2, 5'b00000, pipePkg::None, pipePkg::None);
		addRow(pipePkg::storeHalf, 2'd1, 5'b00010, pipePkg::None, pipePkg::AdES);
		addRow(pipePkg::loadWord, 2'd0, 5'b00000, pipePkg::None, pipePkg::None);
		addRow(pipePkg::loadWord, 2'd3, 5'b00010, pipePkg::None, pipePkg::AdEL);
		addRow(pipePkg::loadHalfSigned, 2'd2, 5'b00000, pipePkg::None, pipePkg::None);
		addRow(pipePkg::loadHalfSigned, 2'd1, 5'b00010, pipePkg::None, pipePkg::AdEL);
		addRow(pipePkg::loadHalfUnsigned, 2'd0, 5'b00000, pipePkg::None, pipePkg::None);
		addRow(pipePkg::loadHalfUnsigned, 2'd3, 5'b00110, pipePkg::None, pipePkg::AdEL);
		addRow(pipePkg::noAccess, 2'd3, 5'b00000, pipePkg::None, pipePkg::None);
		addRow(pipePkg::storeWord, 2'd1, 5'b10000, pipePkg::None, pipePkg::Ov);
		addRow(pipePkg::loadWord, 2'd2, 5'b11000, pipePkg::AdES, pipePkg::AdES);
		addRow(pipePkg::noAccess, 2'd0, 5'b10100, pipePkg::None, pipePkg::Ov);
		addRow(pipePkg::loadHalfSigned, 2'd1, 5'b10001, pipePkg::None, pipePkg::Ov);
		addRow(pipePkg::loadWord, 2'd0, 5'b00000, pipePkg::None, pipePkg::None);
	endtask

	task automatic runFetch();
		logic sawAdEL;
		sawAdEL = 1'b0;
		for (int i = 0; i < 12; i++) begin
			pcWr = (i % 4 != 3);
			ifIdWr = (i % 2 == 1);
			npc = (i == 1) ? (randWord() | 32'h2) : (randWord() & ~32'h3);
			instrData = randWord();
			nextCycle();
			stepFetchModel();
			expectEq("pc", pc, modelPc);
			expectEq("idPc", idPc, modelIdPc);
			expectEq("idInstr", idInstr, modelIdInstr);
			expectEq("idAdEL", 32'(idAdEL), 32'(modelIdAdEL));
			if (idAdEL) sawAdEL = 1'b1;
		end
		assert (sawAdEL) else reportFailure("the misaligned fetch never reached idAdEL");
	endtask

	task automatic applyRow(input int idx);
		rowEntry r;
		logic [31:0] rowAddr;
		logic [31:0] rowPc;
		logic [31:0] wantEpc;
		logic [31:0] wantBad;
		logic seen;
		int waited;
		int flushCount;
		int since;
		r = rows[idx];
		rowPc = randWord() & ~32'h3;
		rowAddr = (randWord() & ~32'h3) | {30'd0, r.addrLow};
		wantEpc = r.flags[2] ? rowPc - 32'd4 : rowPc; // a delay slot restarts at its branch.
		wantBad = r.flags[1] ? rowAddr : rowPc;
		dmRd = r.size[2];
		dmWr = !r.size[2] && (r.size != pipePkg::noAccess);
		size = r.size;
		addr = rowAddr;
		exPc = rowPc;
		overflow = r.flags[4];
		pendingExc = r.flags[3];
		pendingCode = r.pendingCode;
		isBd = r.flags[2];
		instrData = randWord() | 32'h1;
		seen = 1'b0;
		waited = 0;
		while (!seen && waited < WaitLimit) begin
			nextCycle();
			// a squash row stays in EX and sends a second report into the first flush cycle.
			if (waited == 0 && !r.flags[0]) driveIdle();
			seen = excTaken;
			waited++;
		end
		if (r.expCode == pipePkg::None) begin
			expectEq("excTaken", 32'(seen), 32'h0);
			return;
		end
		assert (seen) else reportFailure("no exception was reported before the timeout");
		if (!seen) return;
		expectEq("excTaken latency", waited, 1);
		nextCycle();
		since = 1;
		expectEq("excTaken", 32'(excTaken), 32'h0);
		expectEq("epc", epc, wantEpc);
		expectEq("excCode", 32'(excCode), 32'(r.expCode));
		expectEq("badVAddr", badVAddr, wantBad);
		expectEq("branchDelay", 32'(branchDelay), 32'(r.flags[2]));
		flushCount = 0;
		while (flushing && flushCount < FlushLimit) begin
			flushCount++;
			if (flushCount > 1) expectEq("idInstr", idInstr, 32'h0);
			if (r.flags[0]) begin
				overflow = 1'b1;
				exPc = randWord() & ~32'h3;
			end
			nextCycle();
			since++;
			expectEq("excTaken", 32'(excTaken), 32'h0);
		end
		driveIdle();
		assert (flushCount < FlushLimit)
			else reportFailure("flushing did not end before the timeout");
		expectEq("flush cycles", flushCount, FlushCycles);
		while (since < FlushCycles + 2) begin
			nextCycle();
			since++;
		end
		assert (since == FlushCycles + 2)
			else reportFailure("the flush ran past the redirect point");
		expectEq("pc", pc, ExcVector);
		if (r.flags[0]) begin
			for (int i = 0; i < 3; i++) begin
				nextCycle();
				expectEq("excTaken", 32'(excTaken), 32'h0);
				expectEq("epc", epc, wantEpc);
			end
		end
	endtask

	initial begin
		void'($urandom(32'h3e7a));
		checkCount = 0;
		errorCount = 0;
		testCount = 0;
		testErrors = 0;
		rst = 1'b0;
		npc = '0;
		pcWr = 1'b0;
		instrData = '0;
		ifIdWr = 1'b0;
		driveIdle();
		buildTable();
		repeat (16) @(posedge clk);
		#1;
		rst = 1'b1;

		beginTest();
		expectEq("pc", pc, 32'h0);
		expectEq("excTaken", 32'(excTaken), 32'h0);
		expectEq("flushing", 32'(flushing), 32'h0);
		expectEq("excCode", 32'(excCode), 32'(pipePkg::None));
		expectEq("idInstr", idInstr, 32'h0);
		npc = randWord() & ~32'h3;
		pcWr = 1'b1;
		nextCycle();
		expectEq("pc", pc, ResetVector);
		endTest("reset");

		modelPrePc = npc;
		modelPreAdEL = 1'b0;
		modelPc = ResetVector;
		modelPcAdEL = 1'b0;
		modelIdPc = '0;
		modelIdInstr = '0;
		modelIdAdEL = 1'b0;
		beginTest();
		runFetch();
		endTest("fetch");

		pcWr = 1'b0;
		ifIdWr = 1'b1; // IF/ID keeps loading so the flush has something to clear.
		for (int i = 0; i < rows.size(); i++) begin
			beginTest();
			applyRow(i);
			endTest($sformatf("row %0d", i));
		end

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

/* compile.f */
verilog/pipePkg.sv
verilog/excBus.sv
verilog/fetchStage.sv
verilog/memCheck.sv
verilog/excControl.sv
verilog/flushTimer.sv
verilog/excRecord.sv
verilog/exceptionPipe.sv
testbench/exceptionPipeTb.sv

/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module exceptionPipeTb \
	-o exceptionPipeSim
if [ $? -ne 0 ]; then
	echo "Verilator build error"
	exit 1
fi

output=$(./obj_dir/exceptionPipeSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Testbench passed"; then
	exit 0
fi
exit 1
